/* Makefile */
TOP := tb_soc_periph

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f all.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

/* all.f */
rtl/soc_pkg.sv
rtl/rst_seq.sv
rtl/apb_fabric.sv
rtl/dev_table.sv
rtl/int_ctrl.sv
rtl/interval_timer.sv
rtl/soc_periph_top.sv
testbench/tb_soc_periph.sv

/* rtl/apb_fabric.sv */
////////////////////////////////////////////////////////////
// Slots 0 to 2 are external slaves. Slot 3 is served here.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module apb_fabric import soc_pkg::*; (
	input  logic                     clk120mhz,
	input  logic                     rst_p,
	input  apb_req_t                 m_req_i,
	output apb_rsp_t                 m_rsp_o,
	output apb_req_t [DEV_COUNT-1:0] s_req_o,
	input  apb_rsp_t [DEV_COUNT-1:0] s_rsp_i
);

	slot_t                slot;
	logic [DEV_COUNT-1:0] sel_vec;

	always_comb begin
		case (m_req_i.paddr[15:12])
			4'h0:    slot = SLOT_DEV;
			4'h1:    slot = SLOT_INT;
			4'h2:    slot = SLOT_TMR;
			default: slot = SLOT_DFLT;
		endcase
	end

	// Every slave sees the full request and only its own psel is gated.
	always_comb begin
		for (int i = 0; i < DEV_COUNT; i++) begin
			sel_vec[i]      = m_req_i.psel && (slot == slot_t'(i));
			s_req_o[i]      = m_req_i;
			s_req_o[i].psel = sel_vec[i];
		end
	end

	////////////////////////////////////////////////////////////
	// Response path.

	always_comb begin
		if (slot == SLOT_DFLT) begin
			m_rsp_o.prdata  = '0;
			m_rsp_o.pready  = 1'b1; // The default slave never stalls.
			m_rsp_o.pslverr = 1'b0;
		end else begin
			m_rsp_o = s_rsp_i[slot];
		end
	end

	a_one_sel: assert property (@(posedge clk120mhz) disable iff (rst_p)
		$onehot0(sel_vec));

endmodule

`default_nettype wire

/* rtl/dev_table.sv */
////////////////////////////////////////////////////////////
// Reset here is the cold reset, so scratch lives through a warm one.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module dev_table import soc_pkg::*; (
	input  logic     clk120mhz,
	input  logic     rst_p,
	input  apb_req_t apb_req_i,
	output apb_rsp_t apb_rsp_o,
	output rst_cmd_t rst_cmd_o
);

	logic     wr_en;
	offs_t    offs;
	word_t    scratch_q;
	rst_cmd_t rst_cmd_q;

	assign wr_en = apb_req_i.psel && apb_req_i.penable && apb_req_i.pwrite;
	assign offs  = apb_req_i.paddr[11:0];

	always_ff @(posedge clk120mhz) begin
		if (rst_p) begin
			scratch_q <= '0;
			rst_cmd_q <= RST_NONE;
		end else begin
			rst_cmd_q <= RST_NONE; // The command lasts a single cycle.
			if (wr_en && offs == SCRATCH_REG) begin
				scratch_q <= apb_req_i.pwdata;
			end
			if (wr_en && offs == RST_CMD_REG) begin
				rst_cmd_q <= rst_cmd_t'(apb_req_i.pwdata[1:0]);
			end
		end
	end

	assign rst_cmd_o = rst_cmd_q;

	always_comb begin
		apb_rsp_o.prdata  = '0;
		apb_rsp_o.pready  = 1'b1;
		apb_rsp_o.pslverr = 1'b0;
		case (offs)
			DEV_COUNT_REG: begin
				apb_rsp_o.prdata = word_t'(DEV_COUNT);
			end
			MAP_SIZE_REG, MAP_SIZE_REG + 12'h4, MAP_SIZE_REG + 12'h8: begin
				apb_rsp_o.prdata = DEV_MAP_SIZE;
			end
			SCRATCH_REG: begin
				apb_rsp_o.prdata = scratch_q;
			end
			default: begin
				apb_rsp_o.prdata = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* rtl/int_ctrl.sv */
////////////////////////////////////////////////////////////
// Sources are levels, sampled every cycle. A set beats a clear.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module int_ctrl import soc_pkg::*; (
	input  logic                     clk120mhz,
	input  logic                     rst_p,
	input  apb_req_t                 apb_req_i,
	output apb_rsp_t                 apb_rsp_o,
	input  logic [INT_SRC_COUNT-1:0] src_i,
	output logic                     irq_o
);

	logic                     wr_en;
	offs_t                    offs;
	logic [INT_SRC_COUNT-1:0] pend_q;
	logic [INT_SRC_COUNT-1:0] mask_q;
	logic [INT_SRC_COUNT-1:0] clr;

	assign wr_en = apb_req_i.psel && apb_req_i.penable && apb_req_i.pwrite;
	assign offs  = apb_req_i.paddr[11:0];

	// Writing a one to a pending bit clears it.
	assign clr = (wr_en && offs == PEND_REG) ? apb_req_i.pwdata[INT_SRC_COUNT-1:0] : '0;

	always_ff @(posedge clk120mhz) begin
		if (rst_p) begin
			pend_q <= '0;
			mask_q <= '0;
		end else begin
			pend_q <= (pend_q & ~clr) | src_i;
			if (wr_en && offs == MASK_REG) begin
				mask_q <= apb_req_i.pwdata[INT_SRC_COUNT-1:0];
			end
		end
	end

	assign irq_o = |(pend_q & mask_q);

	always_comb begin
		apb_rsp_o.pready  = 1'b1;
		apb_rsp_o.pslverr = 1'b0;
		case (offs)
			PEND_REG: begin
				apb_rsp_o.prdata = {{(32 - INT_SRC_COUNT){1'b0}}, pend_q};
			end
			MASK_REG: begin
				apb_rsp_o.prdata = {{(32 - INT_SRC_COUNT){1'b0}}, mask_q};
			end
			default: begin
				apb_rsp_o.prdata = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* rtl/interval_timer.sv */
////////////////////////////////////////////////////////////
// Period is load plus one cycles. Writes restart the count.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module interval_timer import soc_pkg::*; (
	input  logic     clk120mhz,
	input  logic     rst_p,
	input  apb_req_t apb_req_i,
	output apb_rsp_t apb_rsp_o,
	output logic     tick_o
);

	logic  wr_en;
	offs_t offs;
	word_t load_q;
	word_t count_q;
	logic  en_q;

	assign wr_en = apb_req_i.psel && apb_req_i.penable && apb_req_i.pwrite;
	assign offs  = apb_req_i.paddr[11:0];

	assign tick_o = en_q && (count_q == '0);

	always_ff @(posedge clk120mhz) begin
		if (rst_p) begin
			load_q  <= '0;
			count_q <= '0;
			en_q    <= 1'b0;
		end else if (wr_en && offs == LOAD_REG) begin
			load_q  <= apb_req_i.pwdata;
			count_q <= apb_req_i.pwdata;
		end else if (wr_en && offs == CTRL_REG) begin
			en_q    <= apb_req_i.pwdata[0];
			count_q <= load_q;
		end else if (en_q) begin
			count_q <= tick_o ? load_q : count_q - 1'b1; // Reload at zero.
		end
	end

	always_comb begin
		apb_rsp_o.pready  = 1'b1;
		apb_rsp_o.pslverr = 1'b0;
		case (offs)
			LOAD_REG:  apb_rsp_o.prdata = load_q;
			CTRL_REG:  apb_rsp_o.prdata = {31'b0, en_q};
			COUNT_REG: apb_rsp_o.prdata = count_q;
			default:   apb_rsp_o.prdata = '0;
		endcase
	end

	a_count_le_load: assert property (@(posedge clk120mhz) disable iff (rst_p)
		count_q <= load_q);

endmodule

`default_nettype wire

/* rtl/rst_seq.sv */
////////////////////////////////////////////////////////////
// Leaving OFF takes rst_p. A lost lock in RUN restarts the hold.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rst_seq import soc_pkg::*; (
	input  logic     clk120mhz,
	input  logic     rst_p,
	input  logic     lock_i,
	input  rst_cmd_t rst_cmd_i,
	output logic     periph_rst_o,
	output logic     cold_rst_o,
	output logic     rst_busy_o,
	output logic     pwr_off_o
);

	typedef enum logic [1:0] {
		HOLD,
		RUN,
		OFF
	} state_e;

	state_e                state_q;
	logic [HOLD_CNT_W-1:0] hold_cnt_q;
	logic                  cold_pend_q;

	always_ff @(posedge clk120mhz) begin
		if (rst_p) begin
			state_q     <= HOLD;
			hold_cnt_q  <= '0;
			cold_pend_q <= 1'b1; // A board reset is a cold reset.
		end else begin
			case (state_q)
				HOLD: begin
					if (!lock_i) begin
						hold_cnt_q <= '0;
					end else if (hold_cnt_q == HOLD_CNT_W'(RST_HOLD_CYCLES - 1)) begin
						state_q     <= RUN;
						cold_pend_q <= 1'b0;
					end else begin
						hold_cnt_q <= hold_cnt_q + 1'b1;
					end
				end
				RUN: begin
					hold_cnt_q <= '0;
					if (rst_cmd_i == RST_PWROFF) begin
						state_q <= OFF;
					end else if (rst_cmd_i == RST_COLD) begin
						state_q     <= HOLD;
						cold_pend_q <= 1'b1;
					end else if (rst_cmd_i == RST_WARM || !lock_i) begin
						state_q <= HOLD;
					end
				end
				OFF: begin
					hold_cnt_q <= '0;
				end
				default: begin
					state_q <= HOLD;
				end
			endcase
		end
	end

	assign periph_rst_o = (state_q != RUN);
	assign rst_busy_o   = (state_q != RUN);
	assign cold_rst_o   = cold_pend_q;
	assign pwr_off_o    = (state_q == OFF);

	// Power-off keeps the peripherals in reset and the system busy.
	a_off_busy: assert property (@(posedge clk120mhz)
		pwr_off_o |-> rst_busy_o && periph_rst_o);

	a_off_sticky: assert property (@(posedge clk120mhz) disable iff (rst_p)
		pwr_off_o |=> pwr_off_o); // No command can wake it.

endmodule

`default_nettype wire

/* rtl/soc_periph_top.sv */
////////////////////////////////////////////////////////////
// One clock domain. The external master must follow APB.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module soc_periph_top import soc_pkg::*; (
	input  logic     clk120mhz,
	input  logic     rst_p,
	input  logic     lock_i,
	input  logic     ext_irq_i,
	input  apb_req_t apb_req_i,
	output apb_rsp_t apb_rsp_o,
	output logic     irq_o,
	output logic     rst_busy_o,
	output logic     pwr_off_o
);

	logic                     periph_rst;
	logic                     cold_rst;
	logic                     tick;
	rst_cmd_t                 rst_cmd;
	apb_req_t [DEV_COUNT-1:0] s_req;
	apb_rsp_t [DEV_COUNT-1:0] s_rsp;

	rst_seq seq_i (
		.clk120mhz    (clk120mhz),
		.rst_p        (rst_p),
		.lock_i       (lock_i),
		.rst_cmd_i    (rst_cmd),
		.periph_rst_o (periph_rst),
		.cold_rst_o   (cold_rst),
		.rst_busy_o   (rst_busy_o),
		.pwr_off_o    (pwr_off_o)
	);

	apb_fabric fabric_i (
		.clk120mhz (clk120mhz),
		.rst_p     (periph_rst),
		.m_req_i   (apb_req_i),
		.m_rsp_o   (apb_rsp_o),
		.s_req_o   (s_req),
		.s_rsp_i   (s_rsp)
	);

	////////////////////////////////////////////////////////////
	// Peripherals.

	dev_table dev_table_i (
		.clk120mhz (clk120mhz),
		.rst_p     (cold_rst), // Only a cold reset clears the table.
		.apb_req_i (s_req[SLOT_DEV]),
		.apb_rsp_o (s_rsp[SLOT_DEV]),
		.rst_cmd_o (rst_cmd)
	);

	int_ctrl int_ctrl_i (
		.clk120mhz (clk120mhz),
		.rst_p     (periph_rst),
		.apb_req_i (s_req[SLOT_INT]),
		.apb_rsp_o (s_rsp[SLOT_INT]),
		.src_i     ({ext_irq_i, tick}),
		.irq_o     (irq_o)
	);

	interval_timer timer_i (
		.clk120mhz (clk120mhz),
		.rst_p     (periph_rst),
		.apb_req_i (s_req[SLOT_TMR]),
		.apb_rsp_o (s_rsp[SLOT_TMR]),
		.tick_o    (tick)
	);

endmodule

`default_nettype wire

/* rtl/soc_pkg.sv */
////////////////////////////////////////////////////////////
// Register offsets are byte addresses inside a 4 KB window.
// Address bits 15 to 12 pick the window.
////////////////////////////////////////////////////////////
`default_nettype none

package soc_pkg;

	typedef logic [31:0] word_t;
	typedef logic [15:0] addr_t;
	typedef logic [11:0] offs_t; // Offset inside one device window.
	typedef logic [1:0]  slot_t;
	typedef logic [1:0]  rst_cmd_t;

	typedef struct packed {
		logic  psel;
		logic  penable;
		logic  pwrite;
		addr_t paddr;
		word_t pwdata;
	} apb_req_t;

	typedef struct packed {
		word_t prdata;
		logic  pready;
		logic  pslverr;
	} apb_rsp_t;

	////////////////////////////////////////////////////////////
	// Address map and reset codes.

	localparam slot_t SLOT_DEV  = 2'd0;
	localparam slot_t SLOT_INT  = 2'd1;
	localparam slot_t SLOT_TMR  = 2'd2;
	localparam slot_t SLOT_DFLT = 2'd3; // Unmapped addresses land here.

	localparam rst_cmd_t RST_NONE   = 2'd0;
	localparam rst_cmd_t RST_PWROFF = 2'd1;
	localparam rst_cmd_t RST_WARM   = 2'd2;
	localparam rst_cmd_t RST_COLD   = 2'd3;

	localparam int    RST_HOLD_CYCLES = 16;
	localparam int    HOLD_CNT_W      = $clog2(RST_HOLD_CYCLES);
	localparam int    DEV_COUNT       = 3;
	localparam word_t DEV_MAP_SIZE    = 32'h0000_1000;
	localparam int    INT_SRC_COUNT   = 2;

	////////////////////////////////////////////////////////////
	// Register offsets.

	localparam offs_t DEV_COUNT_REG = 12'h000;
	localparam offs_t MAP_SIZE_REG  = 12'h004; // The map sizes take one word per device and end at 0x0C.
	localparam offs_t SCRATCH_REG   = 12'h010;
	localparam offs_t RST_CMD_REG   = 12'h014;

	localparam offs_t PEND_REG = 12'h000;
	localparam offs_t MASK_REG = 12'h004;

	localparam offs_t LOAD_REG  = 12'h000;
	localparam offs_t CTRL_REG  = 12'h004;
	localparam offs_t COUNT_REG = 12'h008;

endpackage

`default_nettype wire

/* testbench/soc_periph_tests.txt */
# op addr data expect, all hex. W write, R read and compare, C wait data cycles,
# P set pin addr (0 lock_i, 1 ext_irq_i, 2 rst_p), B wait busy low, S check {pwr_off,busy,irq}.
P 0000 00000001 00000000
B 0000 00000040 00000000
S 0000 00000000 00000000
R 0000 00000000 00000003
R 0004 00000000 00001000
R 0008 00000000 00001000
R 000c 00000000 00001000
R 7000 00000000 00000000
W 2000 0000000a 00000000
W 1004 00000001 00000000
W 2004 00000001 00000000
C 0000 00000014 00000000
R 1000 00000000 00000001
S 0000 00000000 00000001
W 2004 00000000 00000000
W 1000 00000001 00000000
R 1000 00000000 00000000
S 0000 00000000 00000000
P 0001 00000001 00000000
C 0000 00000002 00000000
R 1000 00000000 00000002
S 0000 00000000 00000000
P 0001 00000000 00000000
W 0010 cafef00d 00000000
R 0010 00000000 cafef00d
W 0014 00000002 00000000
C 0000 00000002 00000000
B 0000 00000040 00000000
R 0010 00000000 cafef00d
R 1004 00000000 00000000
W 0014 00000003 00000000
C 0000 00000002 00000000
B 0000 00000040 00000000
R 0010 00000000 00000000
W 0014 00000001 00000000
C 0000 00000002 00000000
S 0000 00000000 00000006
P 0002 00000001 00000000
C 0000 00000002 00000000
P 0002 00000000 00000000
S 0000 00000000 00000002
B 0000 00000040 00000000
S 0000 00000000 00000000

/* testbench/tb_soc_periph.sv */
////////////////////////////////////////////////////////////
// Run from the project root so that the test file is found.
// Outputs are sampled on the falling clock edge.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_soc_periph import soc_pkg::*; ();

	logic     clk120mhz;
	logic     rst_p;
	logic     lock_i;
	logic     ext_irq_i;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	logic     irq_o;
	logic     rst_busy_o;
	logic     pwr_off_o;

	logic [7:0] step_op[$];
	addr_t      step_addr[$];
	word_t      step_data[$];
	word_t      step_exp[$];
	int         line_cnt;
	bit         loaded;
	int         errors;

	soc_periph_top dut_i (
		.clk120mhz  (clk120mhz),
		.rst_p      (rst_p),
		.lock_i     (lock_i),
		.ext_irq_i  (ext_irq_i),
		.apb_req_i  (apb_req),
		.apb_rsp_o  (apb_rsp),
		.irq_o      (irq_o),
		.rst_busy_o (rst_busy_o),
		.pwr_off_o  (pwr_off_o)
	);

	initial begin
		clk120mhz = 1'b0;
		forever #20 clk120mhz = ~clk120mhz; // 40 ns period.
	end

	////////////////////////////////////////////////////////////
	// Helpers.

	task automatic check(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	// Reads every line; lines that do not hold four fields are comments.
	task automatic load_tests();
		int         fd;
		int         n;
		string      line;
		logic [7:0] op;
		addr_t      addr;
		word_t      data;
		word_t      exp;
		fd = $fopen("testbench/soc_periph_tests.txt", "r");
		if (fd == 0) begin
			$display("The test file testbench/soc_periph_tests.txt could not be opened.");
			errors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			line_cnt++;
			n = $sscanf(line, "%s %h %h %h", op, addr, data, exp);
			if (n == 4) begin
				step_op.push_back(op);
				step_addr.push_back(addr);
				step_data.push_back(data);
				step_exp.push_back(exp);
			end
		end
		$fclose(fd);
	endtask

	task automatic apb_xfer(input logic wr, input addr_t addr, input word_t wdata,
			output word_t rdata);
		int n;
		@(posedge clk120mhz);
		apb_req.psel    <= 1'b1; // Setup phase.
		apb_req.penable <= 1'b0;
		apb_req.pwrite  <= wr;
		apb_req.paddr   <= addr;
		apb_req.pwdata  <= wdata;
		@(posedge clk120mhz);
		apb_req.penable <= 1'b1;
		n = 0;
		@(negedge clk120mhz);
		while (!apb_rsp.pready && n < 8) begin
			n++;
			@(negedge clk120mhz);
		end
		check("pready", apb_rsp.pready, 1'b1);
		check("pslverr", apb_rsp.pslverr, 1'b0);
		rdata = apb_rsp.prdata;
		@(posedge clk120mhz);
		apb_req <= '0;
	endtask

	task automatic run_step(input logic [7:0] op, input addr_t addr, input word_t data,
			input word_t exp);
		word_t rd;
		int    n;
		case (op)
			"W": apb_xfer(1'b1, addr, data, rd);
			"R": begin
				apb_xfer(1'b0, addr, '0, rd);
				check($sformatf("prdata[%h]", addr), rd, exp);
			end
			"C": repeat (data) @(posedge clk120mhz);
			"P": begin
				@(posedge clk120mhz);
				case (addr)
					16'h0:   lock_i <= data[0];
					16'h1:   ext_irq_i <= data[0];
					default: rst_p <= data[0];
				endcase
			end
			"B": begin
				n = 0;
				@(negedge clk120mhz);
				while (rst_busy_o && n < data) begin
					n++;
					@(negedge clk120mhz);
				end
				check("rst_busy_o", rst_busy_o, 1'b0);
			end
			"S": begin
				@(negedge clk120mhz);
				check("pwr_off_o", pwr_off_o, exp[2]);
				check("rst_busy_o", rst_busy_o, exp[1]);
				check("irq_o", irq_o, exp[0]);
			end
			default: begin
				$display("The test file holds an unknown operation %s.", op);
				errors++;
			end
		endcase
	endtask

	////////////////////////////////////////////////////////////
	// The watchdog allows 200 cycles for each line of the test file.

	initial begin
		wait (loaded);
		repeat (line_cnt * 200) @(posedge clk120mhz);
		$display("The watchdog expired after %0d cycles before the tests ended.",
			line_cnt * 200);
		$display("Test FAILED");
		$finish;
	end

	initial begin
		int step_errs;
		int passed;
		rst_p     = 1'b1;
		lock_i    = 1'b0;
		ext_irq_i = 1'b0;
		apb_req   = '0;
		errors    = 0;
		passed    = 0;
		line_cnt  = 0;
		load_tests();
		loaded = 1'b1;
		repeat (4) @(posedge clk120mhz);
		rst_p <= 1'b0;
		for (int i = 0; i < step_op.size(); i++) begin
			step_errs = errors;
			run_step(step_op[i], step_addr[i], step_data[i], step_exp[i]);
			if (errors == step_errs) begin
				passed++;
			end
			$display("step %0d %s %h %h %h: %s", i + 1, step_op[i], step_addr[i],
				step_data[i], step_exp[i], (errors == step_errs) ? "ok" : "failed");
		end
		$display("Steps run %0d, passed %0d, failed %0d, errors %0d", step_op.size(),
			passed, step_op.size() - passed, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
